// ==== logic/x86_defs.svh ====
`ifndef X86_DEFS_SVH
`define X86_DEFS_SVH

// Datapath widths
`define WordWidth       16
`define ByteWidth       8

// IP after reset
`define ResetIp         16'h0000

// Opcodes decoded by exact value
`define OpcodeJmpRel8   8'hEB   // Short jump
`define OpcodeJmpRel16  8'hE9   // Near jump
`define OpcodeNop       8'h90
`define OpcodeClc       8'hF8   // Clear CF
`define OpcodeStc       8'hF9   // Set CF
`define OpcodeCmc       8'hF5   // Invert CF

`endif

// ==== logic/x86Pkg.sv ====
`include "x86_defs.svh"

package x86Pkg;

    typedef logic [`WordWidth-1:0] Word;
    typedef logic [`ByteWidth-1:0] Byte;
    typedef logic [2:0]            RegIdx;    // ModRM register number

    // Same order as opcode bits 5:3
    typedef enum logic [2:0] {
        Add, Or, Adc, Sbb, And, Sub, Xor, Cmp
    } AluOp;

    // Decoded instruction kinds
    typedef enum logic [3:0] {
        AluRm,      // ALU with ModRM operand
        AluAcc,     // ALU on AL/AX with immediate
        MovRm,
        MovImm,     // MOV reg, imm
        IncDec,     // 16-bit register only
        FlagOp,     // CLC STC CMC
        JmpRel8,
        JmpRel16,
        Nop
    } InstrClass;

    // Sequencer states
    typedef enum logic [2:0] {
        Fetch, ModrmRead, OperandLo, OperandHi, Exec, ImmLo, ImmHi, StoreWait
    } SeqState;

endpackage

// ==== logic/x86Alu.sv ====
`timescale 1ns/1ps
`include "x86_defs.svh"

module x86Alu (
    input  x86Pkg::AluOp aluOp,
    input  x86Pkg::Word  opA,        // Destination operand
    input  x86Pkg::Word  opB,        // Source operand
    input  logic         aluWide,
    input  logic         carryIn,
    output x86Pkg::Word  aluResult,
    output logic         carryOut
);

    logic [`WordWidth:0] a17;        // Operands with room for the carry
    logic [`WordWidth:0] b17;
    logic [`WordWidth:0] raw;
    logic                arith;      // Carry comes from the adder

    always_comb begin
        a17 = {1'b0, opA};
        b17 = {1'b0, opB};
        if (!aluWide) begin
            // Byte ops carry out of bit 8
            a17[`WordWidth:`ByteWidth] = '0;
            b17[`WordWidth:`ByteWidth] = '0;
        end
        case (aluOp)
            x86Pkg::Add:              raw = a17 + b17;
            x86Pkg::Adc:              raw = a17 + b17 + carryIn;
            x86Pkg::Sbb:              raw = a17 - b17 - carryIn;   // Borrow lands in carry bit
            x86Pkg::Sub, x86Pkg::Cmp: raw = a17 - b17;
            x86Pkg::Or:               raw = a17 | b17;
            x86Pkg::And:              raw = a17 & b17;
            default:                  raw = a17 ^ b17;             // Xor
        endcase
    end

    assign arith = aluOp inside {x86Pkg::Add, x86Pkg::Adc, x86Pkg::Sbb,
                                 x86Pkg::Sub, x86Pkg::Cmp};

    // Logic ops always clear CF
    assign carryOut  = arith & (aluWide ? raw[`WordWidth] : raw[`ByteWidth]);
    assign aluResult = aluWide ? raw[`WordWidth-1:0]
                               : {{`ByteWidth{1'b0}}, raw[`ByteWidth-1:0]};

endmodule

// ==== logic/x86RegFile.sv ====
`timescale 1ns/1ps

module x86RegFile (
    input  logic          clk25,
    input  logic          rstN,
    input  x86Pkg::RegIdx rdSel,
    input  logic          rdWide,
    output x86Pkg::Word   rdData,
    input  logic          wrEn,
    input  x86Pkg::RegIdx wrSel,
    input  logic          wrWide,
    input  x86Pkg::Word   wrData,
    input  x86Pkg::RegIdx baseSel,
    output x86Pkg::Word   baseAddr
);

    // Word slots used for addressing
    localparam int RegBx = 3;
    localparam int RegBp = 5;
    localparam int RegSi = 6;
    localparam int RegDi = 7;

    x86Pkg::Word regs [8];           // AX CX DX BX SP BP SI DI

    // ------------------------------------------------------------------
    // Write port
    // ------------------------------------------------------------------
    always_ff @(posedge clk25 or negedge rstN) begin
        if (!rstN) begin
            regs <= '{default: '0};
        end else if (wrEn) begin
            if (wrWide) begin
                regs[wrSel] <= wrData;
            end else if (wrSel[2]) begin
                regs[wrSel[1:0]][15:8] <= wrData[7:0];   // AH CH DH BH
            end else begin
                regs[wrSel[1:0]][7:0] <= wrData[7:0];    // AL CL DL BL
            end
        end
    end

    // Byte reads come back zero-extended
    always_comb begin
        if (rdWide)
            rdData = regs[rdSel];
        else if (rdSel[2])
            rdData = {8'h00, regs[rdSel[1:0]][15:8]};
        else
            rdData = {8'h00, regs[rdSel[1:0]][7:0]};
    end

    // Register-indirect EA, mod 00 forms
    always_comb begin
        case (baseSel)
            3'd0:    baseAddr = regs[RegBx] + regs[RegSi];
            3'd1:    baseAddr = regs[RegBx] + regs[RegDi];
            3'd2:    baseAddr = regs[RegBp] + regs[RegSi];
            3'd3:    baseAddr = regs[RegBp] + regs[RegDi];
            3'd4:    baseAddr = regs[RegSi];
            3'd5:    baseAddr = regs[RegDi];
            3'd6:    baseAddr = '0;              // Direct form, no disp16 here
            default: baseAddr = regs[RegBx];
        endcase
    end

endmodule

// ==== logic/x86BusPort.sv ====
`timescale 1ns/1ps

module x86BusPort (
    input  logic        clk25,
    input  logic        rstN,
    input  x86Pkg::Word fetchAddr,
    input  logic        storeStart,
    input  x86Pkg::Word storeAddr,
    input  x86Pkg::Word storeData,
    input  logic        storeWide,
    output logic        storeBusy,
    output x86Pkg::Word busAddr,
    output x86Pkg::Byte busWdata,
    output logic        busWrite
);

    x86Pkg::Word addrLat;
    x86Pkg::Word dataLat;
    logic        wideLat;
    logic        hiPhase;            // Writing the upper byte

    // Store sequencer, low byte first
    always_ff @(posedge clk25 or negedge rstN) begin
        if (!rstN) begin
            storeBusy <= 1'b0;
            hiPhase   <= 1'b0;
        end else if (storeStart) begin
            storeBusy <= 1'b1;
            hiPhase   <= 1'b0;
        end else if (storeBusy) begin
            if (wideLat && !hiPhase) begin
                hiPhase <= 1'b1;         // One more byte to go
            end else begin
                storeBusy <= 1'b0;
                hiPhase   <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk25) begin
        if (storeStart) begin
            addrLat <= storeAddr;
            dataLat <= storeData;
            wideLat <= storeWide;
        end
    end

    assign busWrite = storeBusy;
    assign busAddr  = storeBusy ? addrLat + {15'd0, hiPhase} : fetchAddr;
    assign busWdata = hiPhase ? dataLat[15:8] : dataLat[7:0];

endmodule

// ==== logic/x86Sequencer.sv ====
`timescale 1ns/1ps
`include "x86_defs.svh"

module x86Sequencer (
    input  logic          clk25,
    input  logic          rstN,
    input  x86Pkg::Byte   busRdata,
    output x86Pkg::Word   fetchAddr,
    output logic          storeStart,
    output x86Pkg::Word   storeAddr,
    output x86Pkg::Word   storeData,
    output logic          storeWide,
    input  logic          storeBusy,
    output x86Pkg::RegIdx rdSel,
    output logic          rdWide,
    input  x86Pkg::Word   rdData,
    output logic          wrEn,
    output x86Pkg::RegIdx wrSel,
    output logic          wrWide,
    output x86Pkg::Word   wrData,
    output x86Pkg::RegIdx baseSel,
    input  x86Pkg::Word   baseAddr,
    output x86Pkg::AluOp  aluOp,
    output x86Pkg::Word   opA,
    output x86Pkg::Word   opB,
    output logic          aluWide,
    output logic          carryIn,
    input  x86Pkg::Word   aluResult,
    input  logic          carryOut
);

    x86Pkg::SeqState   state;
    x86Pkg::InstrClass cls;          // Instruction in flight
    x86Pkg::AluOp      op;
    x86Pkg::Word       ip;
    x86Pkg::Byte       opcode;
    x86Pkg::Byte       modrm;
    logic              wide;         // Word operation
    logic              dir;          // ModRM d bit, reg is destination
    logic              cf;

    x86Pkg::Word       ea;           // Register-indirect address
    x86Pkg::Word       regVal;       // ModRM reg operand
    x86Pkg::Word       rmVal;        // Memory operand or immediate

    x86Pkg::InstrClass decCls;
    x86Pkg::AluOp      decOp;
    logic              decWide;
    logic              decDir;

    logic              modIsReg;
    logic              memDest;
    logic              noWrite;      // CMP only touches CF
    x86Pkg::Word       rmOperand;
    x86Pkg::Word       movSrc;

    // ------------------------------------------------------------------
    // Opcode decode, straight off the bus in Fetch
    // ------------------------------------------------------------------
    always_comb begin
        decCls  = x86Pkg::Nop;
        decOp   = x86Pkg::AluOp'(busRdata[5:3]);
        decWide = busRdata[0];
        decDir  = busRdata[1];
        casez (busRdata)
            8'b00???0??: decCls = x86Pkg::AluRm;
            8'b00???10?: decCls = x86Pkg::AluAcc;
            8'b100010??: decCls = x86Pkg::MovRm;
            8'b1011????: begin
                decCls  = x86Pkg::MovImm;
                decWide = busRdata[3];           // B8-BF are word forms
            end
            8'b0100????: begin
                decCls  = x86Pkg::IncDec;
                decWide = 1'b1;
            end
            `OpcodeClc, `OpcodeStc, `OpcodeCmc: decCls = x86Pkg::FlagOp;
            `OpcodeJmpRel8: begin
                decCls  = x86Pkg::JmpRel8;
                decWide = 1'b0;                  // One offset byte
            end
            `OpcodeJmpRel16: decCls = x86Pkg::JmpRel16;
            `OpcodeNop:      decCls = x86Pkg::Nop;
            default:         decCls = x86Pkg::Nop;   // Anything else runs as NOP
        endcase
    end

    assign modIsReg  = modrm[7:6] == 2'b11;
    assign memDest   = (cls == x86Pkg::AluRm || cls == x86Pkg::MovRm) && !modIsReg && !dir;
    assign noWrite   = (cls == x86Pkg::AluRm || cls == x86Pkg::AluAcc) && op == x86Pkg::Cmp;
    assign rmOperand = modIsReg ? rdData : rmVal;
    assign movSrc    = dir ? rmOperand : regVal;
    assign baseSel   = (state == x86Pkg::ModrmRead) ? busRdata[2:0] : modrm[2:0];

    always_comb begin
        case (state)
            x86Pkg::OperandLo: fetchAddr = ea;
            x86Pkg::OperandHi: fetchAddr = ea + 16'd1;
            default:           fetchAddr = ip;
        endcase
    end

    // Register read select
    always_comb begin
        rdWide = wide;
        case (cls)
            x86Pkg::AluAcc:                 rdSel = 3'd0;        // AL or AX
            x86Pkg::IncDec, x86Pkg::MovImm: rdSel = opcode[2:0];
            default:                        rdSel = modrm[2:0];  // rm register
        endcase
        if (state == x86Pkg::ModrmRead)
            rdSel = busRdata[5:3];          // reg field while ModRM is on the bus
    end

    // ALU operands, dest in opA
    always_comb begin
        aluOp   = op;
        aluWide = wide;
        carryIn = cf;
        opA     = dir ? regVal : rmOperand;
        opB     = dir ? rmOperand : regVal;
        if (cls == x86Pkg::AluAcc) begin
            opA = rdData;
            opB = rmVal;
        end else if (cls == x86Pkg::IncDec) begin
            aluOp = opcode[3] ? x86Pkg::Sub : x86Pkg::Add;   // 48-4F decrement
            opA   = rdData;
            opB   = 16'd1;
        end
    end

    // Write-back
    always_comb begin
        wrWide = wide;
        wrSel  = dir ? modrm[5:3] : modrm[2:0];
        wrData = aluResult;
        case (cls)
            x86Pkg::AluAcc: wrSel = 3'd0;
            x86Pkg::MovRm:  wrData = movSrc;
            x86Pkg::MovImm: begin
                wrSel  = opcode[2:0];
                wrData = rmVal;
            end
            x86Pkg::IncDec: wrSel = opcode[2:0];
            default:        wrSel = dir ? modrm[5:3] : modrm[2:0];
        endcase
        wrEn = state == x86Pkg::Exec && !memDest && !noWrite &&
               (cls inside {x86Pkg::AluRm, x86Pkg::AluAcc, x86Pkg::MovRm,
                            x86Pkg::MovImm, x86Pkg::IncDec});
    end

    assign storeStart = state == x86Pkg::Exec && memDest && !noWrite && !storeBusy;
    assign storeAddr  = ea;
    assign storeData  = wrData;
    assign storeWide  = wide;

    // ------------------------------------------------------------------
    // Control FSM
    // ------------------------------------------------------------------
    always_ff @(posedge clk25 or negedge rstN) begin
        if (!rstN) begin
            state  <= x86Pkg::Fetch;
            cls    <= x86Pkg::Nop;
            op     <= x86Pkg::Add;
            ip     <= `ResetIp;
            opcode <= `OpcodeNop;
            modrm  <= '0;
            wide   <= 1'b0;
            dir    <= 1'b0;
            cf     <= 1'b0;
        end else begin
            case (state)
                x86Pkg::Fetch: begin
                    opcode <= busRdata;
                    cls    <= decCls;
                    op     <= decOp;
                    wide   <= decWide;
                    dir    <= decDir;
                    ip     <= ip + 16'd1;
                    case (decCls)
                        x86Pkg::AluRm, x86Pkg::MovRm: state <= x86Pkg::ModrmRead;
                        x86Pkg::AluAcc, x86Pkg::MovImm,
                        x86Pkg::JmpRel8, x86Pkg::JmpRel16: state <= x86Pkg::ImmLo;
                        x86Pkg::IncDec: state <= x86Pkg::Exec;
                        x86Pkg::FlagOp: cf <= (busRdata == `OpcodeCmc) ? ~cf : busRdata[0];
                        default:        state <= x86Pkg::Fetch;   // Single byte
                    endcase
                end
                x86Pkg::ModrmRead: begin
                    modrm <= busRdata;
                    ip    <= ip + 16'd1;
                    state <= (busRdata[7:6] == 2'b11) ? x86Pkg::Exec : x86Pkg::OperandLo;
                end
                x86Pkg::OperandLo: state <= wide ? x86Pkg::OperandHi : x86Pkg::Exec;
                x86Pkg::OperandHi: state <= x86Pkg::Exec;
                x86Pkg::ImmLo: begin
                    ip    <= ip + 16'd1;
                    state <= wide ? x86Pkg::ImmHi : x86Pkg::Exec;
                end
                x86Pkg::ImmHi: begin
                    ip    <= ip + 16'd1;
                    state <= x86Pkg::Exec;
                end
                x86Pkg::Exec: begin
                    if (cls == x86Pkg::AluRm || cls == x86Pkg::AluAcc)
                        cf <= carryOut;          // INC and DEC keep CF
                    if (cls == x86Pkg::JmpRel8)
                        ip <= ip + {{8{rmVal[7]}}, rmVal[7:0]};
                    else if (cls == x86Pkg::JmpRel16)
                        ip <= ip + rmVal;
                    state <= storeStart ? x86Pkg::StoreWait : x86Pkg::Fetch;
                end
                default: begin
                    // Leave on the last store byte
                    if (wide)
                        wide <= 1'b0;
                    else
                        state <= x86Pkg::Fetch;
                end
            endcase
        end
    end

    // Operand latches
    always_ff @(posedge clk25) begin
        case (state)
            x86Pkg::ModrmRead: begin
                ea     <= baseAddr;
                regVal <= rdData;
            end
            x86Pkg::OperandLo, x86Pkg::ImmLo: rmVal <= {8'h00, busRdata};
            x86Pkg::OperandHi, x86Pkg::ImmHi: rmVal[15:8] <= busRdata;
            default: ;
        endcase
    end

endmodule

// ==== logic/x86Core.sv ====
`timescale 1ns/1ps

module x86Core (
    input  logic        clk25,
    input  logic        rstN,
    output x86Pkg::Word busAddr,
    input  x86Pkg::Byte busRdata,
    output x86Pkg::Byte busWdata,
    output logic        busWrite
);

    // Sequencer to bus port
    x86Pkg::Word   fetchAddr;
    logic          storeStart;
    x86Pkg::Word   storeAddr;
    x86Pkg::Word   storeData;
    logic          storeWide;
    logic          storeBusy;

    // Register file
    x86Pkg::RegIdx rdSel;
    logic          rdWide;
    x86Pkg::Word   rdData;
    logic          wrEn;
    x86Pkg::RegIdx wrSel;
    logic          wrWide;
    x86Pkg::Word   wrData;
    x86Pkg::RegIdx baseSel;
    x86Pkg::Word   baseAddr;

    // ALU
    x86Pkg::AluOp  aluOp;
    x86Pkg::Word   opA;
    x86Pkg::Word   opB;
    logic          aluWide;
    logic          carryIn;
    x86Pkg::Word   aluResult;
    logic          carryOut;

    x86Sequencer sequencer_i (.*);
    x86RegFile   regFile_i (.*);
    x86Alu       alu_i (.*);
    x86BusPort   busPort_i (.*);

endmodule

// ==== sim/x86CoreTb.sv ====
`timescale 1ns/1ps
`include "x86_defs.svh"

module x86CoreTb;

    localparam logic [2:0] RmBxSi = 3'd0;
    localparam logic [2:0] RmBxDi = 3'd1;
    localparam logic [2:0] RmSi   = 3'd4;
    localparam logic [2:0] RmDi   = 3'd5;
    localparam logic [2:0] RmBx   = 3'd7;

    logic        clk25;
    logic        rstN;
    x86Pkg::Word busAddr;
    x86Pkg::Byte busRdata;
    x86Pkg::Byte busWdata;
    logic        busWrite;

    x86Pkg::Byte mem [65536];        // Memory seen by the DUT
    x86Pkg::Byte refMem [65536];     // Copy the reference model runs on
    x86Pkg::Word refRegs [8];
    logic        refCf;
    x86Pkg::Byte prog [$];           // Program under construction
    logic [23:0] expQ [$];           // Expected stores as address then byte
    logic [23:0] expEntry;
    int          errors = 0;
    int          checkCount = 0;
    int          storeCount = 0;
    int          testCount = 0;
    int          budget = 20;        // Watchdog limit in cycles
    int          cyclesUsed = 0;
    int          seed = 16;

    x86Core dut_i (.*);

    initial begin
        clk25 = 1'b0;
        forever #4 clk25 = ~clk25;   // 8 ns period
    end

    // ------------------------------------------------------------------
    // Memory model with zero wait states
    // ------------------------------------------------------------------
    assign busRdata = mem[busAddr];

    always @(posedge clk25) begin
        if (busWrite)
            mem[busAddr] <= busWdata;
    end

    task automatic checkEq(input logic [15:0] actual, input logic [15:0] expected,
                           input string what);
        checkCount++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // Every bus write must match the head of the queue
    always @(negedge clk25) begin
        if (rstN && busWrite) begin
            storeCount++;
            if (expQ.size() == 0) begin
                errors++;
                $display("Store of %h to address %h arrived when no store was expected",
                         busWdata, busAddr);
            end else begin
                expEntry = expQ.pop_front();
                checkEq(busAddr, expEntry[23:8], "store address");
                checkEq({8'h00, busWdata}, {8'h00, expEntry[7:0]}, "store data");
            end
        end
    end

    // ------------------------------------------------------------------
    // Reference ISA model
    // ------------------------------------------------------------------
    function automatic logic [16:0] aluRef(input logic [2:0] op, input x86Pkg::Word a,
                                           input x86Pkg::Word b, input logic w,
                                           input logic cin);
        int mask;
        int x;
        int y;
        int s;
        logic c;
        mask = w ? 32'hFFFF : 32'h00FF;
        x = a & mask;
        y = b & mask;
        c = 1'b0;                    // Logic ops clear CF
        case (op)
            3'd0: begin s = x + y; c = s > mask; end
            3'd1: s = x | y;
            3'd2: begin s = x + y + int'(cin); c = s > mask; end
            3'd3: begin s = x - y - int'(cin); c = s < 0; end   // Borrow
            3'd4: s = x & y;
            3'd5, 3'd7: begin s = x - y; c = s < 0; end
            default: s = x ^ y;
        endcase
        return {c, x86Pkg::Word'(s & mask)};
    endfunction

    function automatic x86Pkg::Word readReg(input logic [2:0] sel, input logic w);
        if (w)
            return refRegs[sel];
        return sel[2] ? {8'h00, refRegs[sel[1:0]][15:8]} : {8'h00, refRegs[sel[1:0]][7:0]};
    endfunction

    function automatic void writeReg(input logic [2:0] sel, input logic w,
                                     input x86Pkg::Word val);
        if (w)
            refRegs[sel] = val;
        else if (sel[2])
            refRegs[sel[1:0]][15:8] = val[7:0];  // AH to BH
        else
            refRegs[sel[1:0]][7:0] = val[7:0];
    endfunction

    function automatic x86Pkg::Word eaOf(input logic [2:0] rm);
        case (rm)
            3'd0:    return refRegs[3] + refRegs[6];
            3'd1:    return refRegs[3] + refRegs[7];
            3'd2:    return refRegs[5] + refRegs[6];
            3'd3:    return refRegs[5] + refRegs[7];
            3'd4:    return refRegs[6];
            3'd5:    return refRegs[7];
            3'd7:    return refRegs[3];
            default: return 16'h0000;        // Never generated
        endcase
    endfunction

    function automatic x86Pkg::Word readMem(input x86Pkg::Word ea, input logic w);
        return w ? {refMem[ea + 16'd1], refMem[ea]} : {8'h00, refMem[ea]};
    endfunction

    function automatic void storeMem(input x86Pkg::Word ea, input logic w,
                                     input x86Pkg::Word val);
        expQ.push_back({ea, val[7:0]});
        refMem[ea] = val[7:0];
        if (w) begin
            expQ.push_back({ea + 16'd1, val[15:8]});  // High byte follows
            refMem[ea + 16'd1] = val[15:8];
        end
    endfunction

    // Runs the program up to the self-jump and fills expQ
    function automatic void refRun(output int haltIp);
        x86Pkg::Word ip;
        x86Pkg::Word imm16;
        x86Pkg::Word ea;
        x86Pkg::Word regV;
        x86Pkg::Word rmV;
        x86Pkg::Word res;
        x86Pkg::Byte ob;
        x86Pkg::Byte mr;
        logic [16:0] sum;
        logic        w;
        logic        d;
        logic        alu;
        ip = `ResetIp;
        refCf = 1'b0;
        refRegs = '{default: '0};
        expQ.delete();
        haltIp = -1;
        for (int n = 0; n < 4096; n++) begin
            ob = refMem[ip];
            if (ob == `OpcodeJmpRel8 && refMem[ip + 16'd1] == 8'hFE) begin
                haltIp = ip;
                return;
            end
            imm16 = {refMem[ip + 16'd2], refMem[ip + 16'd1]};
            w = ob[0];
            d = ob[1];
            ip = ip + 16'd1;
            if ((ob[7:6] == 2'b00 && !ob[2]) || ob[7:2] == 6'b100010) begin
                alu = ob[7:6] == 2'b00;
                mr = refMem[ip];
                ip = ip + 16'd1;
                ea = eaOf(mr[2:0]);
                regV = readReg(mr[5:3], w);
                rmV = (mr[7:6] == 2'b11) ? readReg(mr[2:0], w) : readMem(ea, w);
                res = d ? rmV : regV;            // MOV source
                if (alu) begin
                    sum = aluRef(ob[5:3], d ? regV : rmV, d ? rmV : regV, w, refCf);
                    refCf = sum[16];
                    res = sum[15:0];
                end
                if (!alu || ob[5:3] != 3'd7) begin
                    if (d)
                        writeReg(mr[5:3], w, res);
                    else if (mr[7:6] == 2'b11)
                        writeReg(mr[2:0], w, res);
                    else
                        storeMem(ea, w, res);
                end
            end else if (ob[7:6] == 2'b00 && ob[2:1] == 2'b10) begin
                sum = aluRef(ob[5:3], readReg(3'd0, w), imm16, w, refCf);
                refCf = sum[16];
                if (ob[5:3] != 3'd7)
                    writeReg(3'd0, w, sum[15:0]);
                ip = ip + 16'd1 + w;
            end else if (ob[7:4] == 4'hB) begin
                writeReg(ob[2:0], ob[3], imm16);
                ip = ip + 16'd1 + ob[3];
            end else if (ob[7:4] == 4'h4) begin
                sum = aluRef(ob[3] ? 3'd5 : 3'd0, refRegs[ob[2:0]], 16'd1, 1'b1, 1'b0);
                refRegs[ob[2:0]] = sum[15:0];    // CF untouched
            end else if (ob == `OpcodeClc || ob == `OpcodeStc) begin
                refCf = ob[0];
            end else if (ob == `OpcodeCmc) begin
                refCf = !refCf;
            end else if (ob == `OpcodeJmpRel8) begin
                ip = ip + 16'd1 + {{8{imm16[7]}}, imm16[7:0]};
            end else if (ob == `OpcodeJmpRel16) begin
                ip = ip + 16'd2 + imm16;
            end
        end
        errors++;
        $display("Reference model never reached the self-jump");
    endfunction

    // ------------------------------------------------------------------
    // Program builder
    // ------------------------------------------------------------------
    function automatic x86Pkg::Word ptrWord();
        return 16'h4000 | ($urandom & 16'h1FFF);    // Data area so sums stay clear of code
    endfunction

    function automatic x86Pkg::Byte flagOpcode(input int i);
        case (i % 3)
            0:       return `OpcodeStc;
            1:       return `OpcodeClc;
            default: return `OpcodeCmc;
        endcase
    endfunction

    task automatic emit(input x86Pkg::Byte b);
        prog.push_back(b);
    endtask

    task automatic emitMovImm(input logic [2:0] sel, input logic w, input x86Pkg::Word val);
        emit({4'hB, w, sel});
        emit(val[7:0]);
        if (w)
            emit(val[15:8]);
    endtask

    task automatic emitModrm(input x86Pkg::Byte opc, input logic [1:0] mode,
                             input logic [2:0] regF, input logic [2:0] rmF);
        emit(opc);
        emit({mode, regF, rmF});
    endtask

    task automatic emitStore(input logic [2:0] sel, input logic w, input logic [2:0] rmF);
        emitModrm({7'b1000100, w}, 2'b00, sel, rmF);   // MOV [rm], reg
    endtask

    task automatic emitAcc(input logic [2:0] op, input logic w, input x86Pkg::Word imm);
        emit({2'b00, op, 2'b10, w});
        emit(imm[7:0]);
        if (w)
            emit(imm[15:8]);
    endtask

    // Fresh program with BX BP SI DI in the data area
    task automatic startProgram();
        prog.delete();
        emitMovImm(3'd3, 1'b1, ptrWord());
        emitMovImm(3'd5, 1'b1, ptrWord());
        emitMovImm(3'd6, 1'b1, ptrWord());
        emitMovImm(3'd7, 1'b1, ptrWord());
    endtask

    task automatic loadMemory();
        for (int a = 0; a < 65536; a++)
            mem[a] = x86Pkg::Byte'(a ^ (a >> 8) ^ 8'h3C);   // Pattern over the full address
        foreach (prog[i])
            mem[i] = prog[i];
        refMem = mem;
    endtask

    // ------------------------------------------------------------------
    // Test runner
    // ------------------------------------------------------------------
    task automatic runProgram(input string name);
        int   haltIp;
        int   entries;
        int   errStart;
        int   storesBefore;
        logic inHalt;
        logic prevHalt;
        emit(`OpcodeJmpRel8);
        emit(8'hFE);                 // Jump to itself
        @(posedge clk25);
        rstN <= 1'b0;
        loadMemory();
        refRun(haltIp);
        budget += 12 * prog.size() + 15;
        errStart = errors;
        storesBefore = storeCount;
        repeat (5) @(posedge clk25);
        rstN <= 1'b1;
        entries = 0;
        prevHalt = 1'b0;
        // Done on the second arrival at the self-jump
        while (entries < 2) begin
            @(negedge clk25);
            inHalt = busAddr == x86Pkg::Word'(haltIp) && !busWrite;
            if (inHalt && !prevHalt)
                entries++;
            prevHalt = inHalt;
        end
        if (expQ.size() != 0) begin
            errors++;
            $display("%0d expected stores never appeared in test %s", expQ.size(), name);
            expQ.delete();
        end
        testCount++;
        $display("Test %-12s %0d bytes, %0d stores, %0d errors", name, prog.size(),
                 storeCount - storesBefore, errors - errStart);
    endtask

    task automatic movImmTest();
        x86Pkg::Word val;
        for (int w = 0; w < 2; w++) begin
            for (int sel = 0; sel < 8; sel++) begin
                if (sel == 0 && w == 0)
                    startProgram();
                val = $urandom;
                if (w == 1 && sel == 3)
                    val = ptrWord();                         // BX stays a pointer
                if (w == 0 && sel == 7)
                    val[7:0] = 8'h40 | (val[7:0] & 8'h1F);   // BH likewise
                emitMovImm(3'(sel), 1'(w), val);
                emitStore(3'(sel), 1'(w), RmBx);
            end
        end
        runProgram("movImm");
    endtask

    task automatic aluRegTest();
        logic [2:0] dst;
        logic [2:0] src;
        logic       d;
        startProgram();
        for (int w = 0; w < 2; w++) begin
            for (int op = 0; op < 8; op++) begin
                dst = w ? $urandom % 6 : $urandom % 8;   // SI and DI kept for stores
                src = w ? $urandom % 6 : $urandom % 8;
                d = $urandom % 2;
                emitMovImm(src, 1'(w), $urandom);
                emitMovImm(dst, 1'(w), $urandom);
                if (d)
                    emitModrm({2'b00, 3'(op), 2'b01, 1'(w)}, 2'b11, dst, src);
                else
                    emitModrm({2'b00, 3'(op), 2'b00, 1'(w)}, 2'b11, src, dst);
                emitStore(dst, 1'(w), op[0] ? RmDi : RmSi);
            end
        end
        runProgram("aluReg");
    endtask

    task automatic aluAccTest();
        startProgram();
        for (int w = 0; w < 2; w++) begin
            for (int op = 0; op < 8; op++) begin
                emitMovImm(3'd0, 1'(w), $urandom);
                emit(flagOpcode(op + w));
                emitAcc(3'(op), 1'(w), $urandom);
                emitStore(3'd0, 1'(w), RmSi);
                emitAcc(x86Pkg::Adc, 1'b0, 16'h0000);   // CF shows up in AL
                emitStore(3'd0, 1'b0, RmDi);
            end
        end
        runProgram("aluAcc");
    endtask

    task automatic memOperandTest();
        logic [2:0] regF;
        logic [2:0] rmF;
        logic       d;
        startProgram();
        for (int w = 0; w < 2; w++) begin
            for (int op = 0; op < 8; op++) begin
                regF = $urandom % 3;
                rmF = $urandom % 7;
                if (rmF == 3'd6)
                    rmF = RmBx;                  // No direct form
                d = $urandom % 2;
                emitMovImm(regF, 1'(w), $urandom);
                emitModrm({2'b00, 3'(op), 1'b0, d, 1'(w)}, 2'b00, regF, rmF);
                if (d)
                    emitStore(regF, 1'(w), RmBxDi);
                d = $urandom % 2;
                emitModrm({6'b100010, d, 1'(w)}, 2'b00, regF, rmF);
                if (d)
                    emitStore(regF, 1'(w), RmBxDi);
            end
        end
        runProgram("memOperand");
    endtask

    task automatic incDecJmpTest();
        logic [2:0]  regF;
        x86Pkg::Word val;
        startProgram();
        for (int i = 0; i < 6; i++) begin
            regF = i % 3;
            val = (i == 0) ? 16'hFFFF : (i == 1) ? 16'h0000 : x86Pkg::Word'($urandom);
            emitMovImm(regF, 1'b1, val);
            emit((i < 2) ? `OpcodeClc : flagOpcode(i));   // Wrapping passes start with CF clear
            emit({4'h4, i[0], regF});            // Odd passes decrement
            emitStore(regF, 1'b1, RmDi);
            emitAcc(x86Pkg::Adc, 1'b0, 16'h0000);
            emitStore(3'd0, 1'b0, RmSi);
            emit(`OpcodeJmpRel8);
            emit(8'h02);
            emitStore(3'd0, 1'b0, RmBx);         // Skipped
            emit(`OpcodeJmpRel16);
            emit(8'h02);
            emit(8'h00);
            emitStore(3'd0, 1'b1, RmBxSi);       // Skipped
        end
        runProgram("incDecJmp");
    endtask

    // ------------------------------------------------------------------
    // Main sequence and watchdog
    // ------------------------------------------------------------------
    initial begin
        rstN = 1'b0;
        void'($urandom(seed));
        movImmTest();
        aluRegTest();
        aluAccTest();
        memOperandTest();
        incDecJmpTest();
        $display("Tests %0d, checks %0d, stores %0d, errors %0d",
                 testCount, checkCount, storeCount, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial begin
        while (cyclesUsed <= budget) begin
            @(posedge clk25);
            cyclesUsed++;
        end
        $display("Timeout after %0d cycles, the core never reached its self-jump", cyclesUsed);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+logic
logic/x86Pkg.sv
logic/x86Alu.sv
logic/x86RegFile.sv
logic/x86BusPort.sv
logic/x86Sequencer.sv
logic/x86Core.sv
sim/x86CoreTb.sv
